//--- logic/ahbPkg.sv
//**************************************************
// AHB-Lite memory system shared definitions
// transfer types, RAM slave states and memory map
//**************************************************
package ahbPkg;

    // htrans encodings as defined by AHB-Lite
    typedef enum logic [1:0] {
        idle   = 2'b00,
        busy   = 2'b01,
        nonSeq = 2'b10,
        seq    = 2'b11
    } transType;

    // RAM slave FSM states
    // the read/write state also holds the captured write flag
    typedef enum logic [1:0] {
        memIdle  = 2'b00,
        memRead  = 2'b01,
        memWrite = 2'b10
    } memState;

    // memory map
    // each RAM owns one 64 KB region, only the low part is populated
    localparam logic [31:0] mem0Base = 32'h0000_0000;
    localparam logic [31:0] mem1Base = 32'h0001_0000;

    // low address bits that index inside one region
    localparam int regionBits = 16;

endpackage

//--- logic/ahbBus.sv
//**************************************************
// AHB-Lite shared address-phase signals and bus ready
//**************************************************
`timescale 1ns/1ps

interface ahbBus;

    // address phase, driven by the master
    logic [31:0]      hAddr;
    ahbPkg::transType hTrans;
    logic             hWrite;
    logic [2:0]       hSize;

    // data phase write data
    logic [31:0]      hWdata;

    // bus ready, fed back from the response mux
    logic             hReady;

    modport slave (
        input hAddr,
        input hTrans,
        input hWrite,
        input hSize,
        input hWdata,
        input hReady
    );

    modport decoder (
        input hAddr,
        input hTrans
    );

    modport mux (
        output hReady,
        input  hTrans
    );

    modport top (
        output hAddr,
        output hTrans,
        output hWrite,
        output hSize,
        output hWdata,
        input  hReady
    );

endinterface

//--- logic/ahbDecoder.sv
//**************************************************
// AHB-Lite address decoder
// one-hot select of RAM 0, RAM 1 or the default slave
//**************************************************
`timescale 1ns/1ps

module ahbDecoder #(
    parameter int mem0AddrWidth = 10,
    parameter int mem1AddrWidth = 8
) (
    ahbBus.decoder bus,
    output logic   sel0,
    output logic   sel1,
    output logic   selDefault
);

    localparam logic [31:0] regionMask = (32'd1 << ahbPkg::regionBits) - 32'd1;
    localparam logic [31:0] mem0Size   = 32'd1 << mem0AddrWidth;
    localparam logic [31:0] mem1Size   = 32'd1 << mem1AddrWidth;

    logic [31:0] regionBase;
    logic [31:0] offset;
    logic        active;
    logic        hit0;
    logic        hit1;

    assign regionBase = bus.hAddr & ~regionMask;
    assign offset     = bus.hAddr & regionMask;
    assign active     = (bus.hTrans == ahbPkg::nonSeq) || (bus.hTrans == ahbPkg::seq);

    // an address past the populated part of a region is unmapped
    assign hit0 = (regionBase == ahbPkg::mem0Base) && (offset < mem0Size);
    assign hit1 = (regionBase == ahbPkg::mem1Base) && (offset < mem1Size);

    // idle and busy go to the default slave, which answers them with a zero-wait OKAY
    assign sel0       = active && hit0;
    assign sel1       = active && hit1;
    assign selDefault = !(sel0 || sel1);

    always_comb begin
        assert ($onehot({sel0, sel1, selDefault}))
        else $error("decoder selects not one-hot for address %h", bus.hAddr);
    end

endmodule

//--- logic/ahbMemSlave.sv
//**************************************************
// AHB-Lite on-chip RAM slave
// one wait state per transfer, byte and halfword writes
//**************************************************
`timescale 1ns/1ps

module ahbMemSlave #(
    parameter int memAddrWidth = 10
) (
    input  logic        HCLK,
    input  logic        HRESETn,
    ahbBus.slave        bus,
    input  logic        sel,
    output logic [31:0] rdata,
    output logic        readyOut,
    output logic        resp
);

    localparam int memWords = (2 ** memAddrWidth) / 4;

    ahbPkg::memState state;
    ahbPkg::memState nextState;

    logic [31:0]             mem [memWords];
    logic [memAddrWidth-1:0] addrQ;
    logic [2:0]              sizeQ;
    logic [3:0]              byteEn;
    logic                    accept;
    logic                    active;

    assign active = (bus.hTrans == ahbPkg::nonSeq) || (bus.hTrans == ahbPkg::seq);

    // address phase is only taken when the whole bus is ready
    assign accept = (state == ahbPkg::memIdle) && sel && active && bus.hReady;

    // the wait state is the read or write cycle itself
    assign readyOut = (state == ahbPkg::memIdle);
    assign resp     = 1'b0;

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            state <= ahbPkg::memIdle;
        end else begin
            state <= nextState;
        end
    end

    // write flag of the transfer is kept as the choice of memRead or memWrite
    always_comb begin
        nextState = state;
        unique case (state)
            ahbPkg::memIdle: begin
                if (accept) begin
                    nextState = bus.hWrite ? ahbPkg::memWrite : ahbPkg::memRead;
                end
            end
            ahbPkg::memRead:  nextState = ahbPkg::memIdle;
            ahbPkg::memWrite: nextState = ahbPkg::memIdle;
            default:          nextState = ahbPkg::memIdle;
        endcase
    end

    // capture the address phase for the following data phase
    always_ff @(posedge HCLK) begin
        if (accept) begin
            addrQ <= bus.hAddr[memAddrWidth-1:0];
            sizeQ <= bus.hSize;
        end
    end

    // little-endian lane selection
    always_comb begin
        case (sizeQ)
            3'd0:    byteEn = 4'b0001 << addrQ[1:0];
            3'd1:    byteEn = addrQ[1] ? 4'b1100 : 4'b0011;
            default: byteEn = 4'b1111;
        endcase
    end

    // hWdata is valid during the wait state, commit at its end
    always_ff @(posedge HCLK) begin
        if (state == ahbPkg::memWrite) begin
            for (int i = 0; i < 4; i++) begin
                if (byteEn[i]) begin
                    mem[addrQ[memAddrWidth-1:2]][8*i +: 8] <= bus.hWdata[8*i +: 8];
                end
            end
        end
    end

    // full word read, valid once ready returns high
    always_ff @(posedge HCLK) begin
        if (state == ahbPkg::memRead) begin
            rdata <= mem[addrQ[memAddrWidth-1:2]];
        end
    end

    // exactly one wait state per transfer
    stateReturnsIdle: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        (state != ahbPkg::memIdle) |=> (state == ahbPkg::memIdle)
    ) else $error("RAM slave stayed out of memIdle for more than one cycle");

    // wider than a word does not fit the 32-bit data bus
    sizeFitsWord: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        accept |-> (bus.hSize <= 3'd2)
    ) else $error("hSize %0d above word on an accepted transfer", bus.hSize);

endmodule

//--- logic/ahbResponseMux.sv
//**************************************************
// AHB-Lite data-phase response mux
// routes the owning slave back, holds the default slave
//**************************************************
`timescale 1ns/1ps

module ahbResponseMux (
    input  logic        HCLK,
    input  logic        HRESETn,
    ahbBus.mux          bus,
    input  logic        sel0,
    input  logic        sel1,
    input  logic        selDefault,
    input  logic [31:0] rdata0,
    input  logic [31:0] rdata1,
    input  logic        ready0,
    input  logic        ready1,
    input  logic        resp0,
    input  logic        resp1,
    output logic [31:0] hRdata,
    output logic        hResp
);

    // default slave answering unmapped transfers with a two-cycle ERROR
    typedef enum logic [1:0] {
        defOkay  = 2'b00,
        defWait  = 2'b01,
        defError = 2'b10
    } defState;

    defState state;
    logic    own0;
    logic    own1;
    logic    ownDefault;
    logic    defAccept;
    logic    readyMux;

    assign defAccept = bus.hReady && selDefault &&
                       ((bus.hTrans == ahbPkg::nonSeq) || (bus.hTrans == ahbPkg::seq));

    // data-phase owner follows the address phase on every ready edge
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            own0       <= 1'b0;
            own1       <= 1'b0;
            ownDefault <= 1'b1;
        end else if (bus.hReady) begin
            own0       <= sel0;
            own1       <= sel1;
            ownDefault <= selDefault;
        end
    end

    // back-to-back unmapped transfers restart the ERROR sequence
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            state <= defOkay;
        end else begin
            case (state)
                defOkay:  state <= defAccept ? defWait : defOkay;
                defWait:  state <= defError;
                defError: state <= defAccept ? defWait : defOkay;
                default:  state <= defOkay;
            endcase
        end
    end

    always_comb begin
        hRdata   = 32'd0;
        readyMux = 1'b1;
        hResp    = 1'b0;
        if (own0) begin
            hRdata   = rdata0;
            readyMux = ready0;
            hResp    = resp0;
        end else if (own1) begin
            hRdata   = rdata1;
            readyMux = ready1;
            hResp    = resp1;
        end else if (ownDefault) begin
            readyMux = (state != defWait);
            hResp    = (state != defOkay);
        end
    end

    assign bus.hReady = readyMux;

    // ERROR must take its first cycle with ready low
    errorTwoCycle: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        (hResp && bus.hReady) |-> $past(hResp && !bus.hReady)
    ) else $error("ERROR completed without its wait cycle");

endmodule

//--- logic/ahbMemSystem.sv
//**************************************************
// AHB-Lite memory system top level
// decoder, two RAM slaves and the response mux
//**************************************************
`timescale 1ns/1ps

module ahbMemSystem #(
    parameter int mem0AddrWidth = 10,
    parameter int mem1AddrWidth = 8
) (
    input  logic             HCLK,
    input  logic             HRESETn,
    input  logic [31:0]      hAddr,
    input  ahbPkg::transType hTrans,
    input  logic             hWrite,
    input  logic [2:0]       hSize,
    input  logic [31:0]      hWdata,
    output logic [31:0]      hRdata,
    output logic             hReady,
    output logic             hResp
);

    logic        sel0;
    logic        sel1;
    logic        selDefault;
    logic [31:0] rdata0;
    logic [31:0] rdata1;
    logic        ready0;
    logic        ready1;
    logic        resp0;
    logic        resp1;

    ahbBus bus ();

    // master side onto the shared bus
    assign bus.hAddr  = hAddr;
    assign bus.hTrans = hTrans;
    assign bus.hWrite = hWrite;
    assign bus.hSize  = hSize;
    assign bus.hWdata = hWdata;
    assign hReady     = bus.hReady;

    ahbDecoder #(
        .mem0AddrWidth(mem0AddrWidth),
        .mem1AddrWidth(mem1AddrWidth)
    ) decoder (
        .bus       (bus),
        .sel0      (sel0),
        .sel1      (sel1),
        .selDefault(selDefault)
    );

    ahbMemSlave #(
        .memAddrWidth(mem0AddrWidth)
    ) mem0 (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .bus     (bus),
        .sel     (sel0),
        .rdata   (rdata0),
        .readyOut(ready0),
        .resp    (resp0)
    );

    ahbMemSlave #(
        .memAddrWidth(mem1AddrWidth)
    ) mem1 (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .bus     (bus),
        .sel     (sel1),
        .rdata   (rdata1),
        .readyOut(ready1),
        .resp    (resp1)
    );

    ahbResponseMux responseMux (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .bus       (bus),
        .sel0      (sel0),
        .sel1      (sel1),
        .selDefault(selDefault),
        .rdata0    (rdata0),
        .rdata1    (rdata1),
        .ready0    (ready0),
        .ready1    (ready1),
        .resp0     (resp0),
        .resp1     (resp1),
        .hRdata    (hRdata),
        .hResp     (hResp)
    );

endmodule

//--- sim/ahbMemSystemTb.sv
//**************************************************
// AHB-Lite memory system testbench
// pipelined master, reference RAM model and checkers
//**************************************************
`timescale 1ns/1ps

module ahbMemSystemTb;

    localparam int mem0AddrWidth = 10;
    localparam int mem1AddrWidth = 8;
    localparam int readyTimeout  = 16;

    logic             HCLK = 1'b0;
    logic             HRESETn;
    logic [31:0]      hAddr;
    ahbPkg::transType hTrans;
    logic             hWrite;
    logic [2:0]       hSize;
    logic [31:0]      hWdata;
    logic [31:0]      hRdata;
    logic             hReady;
    logic             hResp;

    // master's view of the transfer in its data phase
    logic        dpActive;
    logic        dpMapped;
    logic        dpWrite;
    logic [31:0] dpAddr;
    logic [2:0]  dpSize;
    int          dpWaits;
    logic        seenActive;
    logic        addrActive;
    logic [31:0] refMem [512];
    logic [31:0] expRdata;
    logic [31:0] nextWdata;
    int          errors;
    int          testsRun;
    int          testsFailed;
    int          testStart;

    ahbMemSystem #(
        .mem0AddrWidth(mem0AddrWidth),
        .mem1AddrWidth(mem1AddrWidth)
    ) UUT (.*);

    always #5 HCLK = ~HCLK;

    // RAM 0 words sit in the lower half of the model, RAM 1 in the upper
    function automatic int refIndex(logic [31:0] addr);
        return 256 * int'(addr[16]) + int'(addr[9:2]);
    endfunction

    function automatic logic isMapped(logic [31:0] addr);
        if (addr[31:16] == 16'h0000) begin
            return addr[15:0] < (16'd1 << mem0AddrWidth);
        end
        if (addr[31:16] == 16'h0001) begin
            return addr[15:0] < (16'd1 << mem1AddrWidth);
        end
        return 1'b0;
    endfunction

    // little-endian lanes touched by a write of the given size
    function automatic logic laneWritten(logic [2:0] size, logic [1:0] low, int lane);
        case (size)
            3'd0:    return lane == int'(low);
            3'd1:    return (lane / 2) == int'(low[1]);
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic [31:0] fillValue(logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ ~addr ^ 32'h5a3c_96e1;
    endfunction

    assign addrActive = (hTrans == ahbPkg::nonSeq) || (hTrans == ahbPkg::seq);
    assign expRdata   = refMem[refIndex(dpAddr)];

    always @(posedge HCLK) begin
        if (!HRESETn) begin
            dpActive   <= 1'b0;
            dpMapped   <= 1'b0;
            dpWrite    <= 1'b0;
            dpAddr     <= 32'd0;
            dpSize     <= 3'd2;
            dpWaits    <= 0;
            seenActive <= 1'b0;
        end else if (hReady) begin
            // a write lands in the model as its data phase completes
            if (dpActive && dpMapped && dpWrite) begin
                for (int i = 0; i < 4; i++) begin
                    if (laneWritten(dpSize, dpAddr[1:0], i)) begin
                        refMem[refIndex(dpAddr)][8*i +: 8] <= hWdata[8*i +: 8];
                    end
                end
            end
            dpActive <= addrActive;
            dpMapped <= isMapped(hAddr);
            dpWrite  <= hWrite;
            dpAddr   <= hAddr;
            dpSize   <= hSize;
            dpWaits  <= 0;
            if (addrActive) begin
                seenActive <= 1'b1;
            end
        end else begin
            dpWaits <= dpWaits + 1;
        end
    end

    resetQuiet: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        !seenActive |-> (hReady && !hResp)
    ) else begin
        errors++;
        $display("Mismatch at %0t: hReady/hResp expected 1/0, got %b/%b",
                 $time, $sampled(hReady), $sampled(hResp));
    end

    readData: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        (hReady && dpActive && dpMapped && !dpWrite) |-> (hRdata == expRdata)
    ) else begin
        errors++;
        $display("Mismatch at %0t: hRdata expected %h, got %h (address %h)",
                 $time, $sampled(expRdata), $sampled(hRdata), $sampled(dpAddr));
    end

    respMatch: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        hResp == (dpActive && !dpMapped)
    ) else begin
        errors++;
        $display("Mismatch at %0t: hResp expected %b, got %b (address %h)",
                 $time, $sampled(dpActive && !dpMapped), $sampled(hResp), $sampled(dpAddr));
    end

    // active transfers wait exactly once, idle and busy never
    waitCount: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        hReady |-> (dpWaits == (dpActive ? 1 : 0))
    ) else begin
        errors++;
        $display("Mismatch at %0t: hReady low cycles expected %0d, got %0d",
                 $time, $sampled(dpActive ? 1 : 0), $sampled(dpWaits));
    end

    noExtraWait: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        !hReady |-> (dpActive && (dpWaits == 0))
    ) else begin
        errors++;
        $display("hReady held low too long or on an idle data phase at %0t", $time);
    end

    // drives one address phase plus the previous transfer's write data
    task automatic issue(input ahbPkg::transType trans, input logic write,
                         input logic [2:0] size, input logic [31:0] addr,
                         input logic [31:0] wdata);
        int waited;
        @(negedge HCLK);
        hWdata = nextWdata;
        hAddr  = addr;
        hTrans = trans;
        hWrite = write;
        hSize  = size;
        waited = 0;
        while (!hReady && waited < readyTimeout) begin
            @(negedge HCLK);
            waited++;
        end
        if (!hReady) begin
            errors++;
            $display("timeout at %0t: hReady stayed low for %0d cycles", $time, waited);
        end
        nextWdata = wdata;
    endtask

    // lets the last transfer finish its data phase
    task automatic drain();
        issue(ahbPkg::idle, 1'b0, 3'd2, 32'd0, 32'd0);
        @(negedge HCLK);
    endtask

    task automatic store(input logic [31:0] addr, input logic [2:0] size,
                         input logic [31:0] data);
        issue(ahbPkg::nonSeq, 1'b1, size, addr, data);
    endtask

    task automatic load(input logic [31:0] addr);
        issue(ahbPkg::nonSeq, 1'b0, 3'd2, addr, 32'd0);
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (errors == testStart) begin
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: FAILED with %0d errors", name, errors - testStart);
        end
        testStart = errors;
    endtask

    initial begin
        logic [31:0] addr;
        logic [2:0]  size;
        int          pick;
        void'($urandom(32'h76f9_8957));
        HRESETn     = 1'b0;
        hAddr       = 32'd0;
        hTrans      = ahbPkg::idle;
        hWrite      = 1'b0;
        hSize       = 3'd2;
        hWdata      = 32'd0;
        nextWdata   = 32'd0;
        errors      = 0;
        testsRun    = 0;
        testsFailed = 0;
        testStart   = 0;
        repeat (5) @(negedge HCLK);
        HRESETn = 1'b1;

        repeat (4) issue(ahbPkg::idle, 1'b0, 3'd2, 32'h0000_0010, 32'd0);
        drain();
        endTest("reset");

        for (int a = 0; a < 1024; a += 4) store(a, 3'd2, fillValue(a));
        for (int a = 0; a < 256; a += 4) store(32'h0001_0000 + a, 3'd2, fillValue(32'h0001_0000 + a));
        for (int a = 0; a < 1024; a += 4) load(a);
        for (int a = 0; a < 256; a += 4) load(32'h0001_0000 + a);
        // top word of each RAM, read straight behind the write
        store(32'h0000_03fc, 3'd2, $urandom);
        load(32'h0000_03fc);
        store(32'h0001_00fc, 3'd2, $urandom);
        load(32'h0001_00fc);
        drain();
        endTest("wordRW");

        for (int r = 0; r < 2; r++) begin
            addr = (r == 0) ? 32'h0000_0010 : 32'h0001_0010;
            store(addr + 32'd1, 3'd0, $urandom);
            store(addr + 32'd3, 3'd0, $urandom);
            store(addr + 32'd16, 3'd1, $urandom);
            store(addr + 32'd18, 3'd0, $urandom);
            store(addr + 32'd34, 3'd1, $urandom);
            load(addr);
            load(addr + 32'd16);
            load(addr + 32'd32);
        end
        drain();
        endTest("lanes");

        load(32'h0000_0040);
        issue(ahbPkg::busy, 1'b0, 3'd2, 32'h0000_0044, 32'd0);
        load(32'h0001_0040);
        issue(ahbPkg::idle, 1'b0, 3'd2, 32'h0001_0044, 32'd0);
        store(32'h0000_0048, 3'd2, $urandom);
        issue(ahbPkg::busy, 1'b1, 3'd2, 32'h0000_004c, 32'd0);
        load(32'h0000_0048);
        drain();
        endTest("waits");

        store(32'h0002_0000, 3'd2, 32'hdead_0001);
        // would alias word 0 of each RAM if decoded by the low bits only
        store(32'h0001_0100, 3'd2, 32'hdead_0002);
        store(32'h0000_0400, 3'd2, 32'hdead_0003);
        load(32'hffff_fff0);
        load(32'h0001_0000);
        load(32'h0000_0000);
        drain();
        endTest("unmapped");

        for (int n = 0; n < 200; n++) begin
            pick = $urandom % 6;
            size = 3'($urandom % 3);
            case (pick)
                0, 1:    addr = $urandom % 1024;
                2, 3:    addr = 32'h0001_0000 + ($urandom % 256);
                4:       addr = 32'h0002_0000 + ($urandom % 32'h00fe_0000);
                default: addr = 32'h0001_0100 + ($urandom % 32'h0000_ff00);
            endcase
            addr = addr & ~((32'd1 << size) - 32'd1);
            issue((($urandom % 4) == 0) ? ahbPkg::seq : ahbPkg::nonSeq,
                  ($urandom % 2) == 1, size, addr, $urandom);
        end
        drain();
        endTest("random");

        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- files.f
logic/ahbPkg.sv
logic/ahbBus.sv
logic/ahbDecoder.sv
logic/ahbMemSlave.sv
logic/ahbResponseMux.sv
logic/ahbMemSystem.sv
sim/ahbMemSystemTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module ahbMemSystemTb
	out=$$(./obj_dir/VahbMemSystemTb); echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
